// ==== logic/gps_pkg.sv ====
package gps_pkg;

    // ************************************************
    // Widths that carry a meaning
    // ************************************************
    typedef logic [5:0]  sv_num_t;   // Satellite number, 1 to 32
    typedef logic [11:0] lfsr12_t;   // One P-code register
    typedef logic [12:0] ca_word_t;  // Captured C/A chips
    typedef logic [3:0]  wb_addr_t;  // Wishbone word address
    typedef logic [31:0] wb_data_t;  // Wishbone data

    // Number of C/A chips per round
    localparam int ca_chips = 13;

    // Round configuration, held in the bus registers
    typedef struct packed {
        sv_num_t sv_num;
        lfsr12_t ini_x1a;
        lfsr12_t ini_x1b;
        lfsr12_t ini_x2a;
        lfsr12_t ini_x2b;
    } round_cfg_t;

    // Generator control, same shape for both generators
    typedef struct packed {
        logic load;    // Reload from initial state
        logic enable;  // Step one chip
    } gen_ctrl_t;

    typedef enum logic [1:0] {
        seq_idle,
        seq_load,
        seq_run,
        seq_done
    } seq_state_t;

    // Register map
    localparam wb_addr_t reg_ctrl   = 4'd0;  // Start, sv_num
    localparam wb_addr_t reg_status = 4'd1;  // Done, busy
    localparam wb_addr_t reg_x1     = 4'd2;
    localparam wb_addr_t reg_x2     = 4'd3;
    localparam wb_addr_t reg_ca     = 4'd4;
    localparam wb_addr_t reg_p0     = 4'd8;  // P words from here up

endpackage

// ==== logic/gps_wb_regs.sv ====
`timescale 1ns/100ps

module gps_wb_regs #(
    parameter int P_BITS = 64
) (
    input  logic                gps_clk_fast,
    input  logic                sync_rst_in,
    input  logic                wb_cyc,
    input  logic                wb_stb,
    input  logic                wb_we,
    input  gps_pkg::wb_addr_t   wb_adr,
    input  gps_pkg::wb_data_t   wb_dat_w,
    output gps_pkg::wb_data_t   wb_dat_r,
    output logic                wb_ack,
    output gps_pkg::round_cfg_t cfg,
    output logic                start,
    input  logic                busy,
    input  logic                done,
    input  gps_pkg::ca_word_t   ca_word,
    input  logic [P_BITS-1:0]   p_word
);

    logic              acc;      // Access accepted this cycle
    logic [255:0]      p_pad;    // P words padded to full map
    gps_pkg::wb_data_t rd_mux;

    assign acc   = wb_cyc & wb_stb & ~wb_ack;  // Never ack twice in a row
    assign p_pad = 256'(p_word);

    // ************************************************
    // Writes, ack and start pulse
    // ************************************************
    always_ff @(posedge gps_clk_fast) begin
        if (sync_rst_in) begin
            wb_ack <= 1'b0;
            start  <= 1'b0;
            cfg    <= '0;
        end else begin
            wb_ack <= acc;
            // Start lines up with the ack of the ctrl write
            start  <= acc & wb_we & (wb_adr == gps_pkg::reg_ctrl) & wb_dat_w[0];
            if (acc && wb_we) begin
                case (wb_adr)
                    gps_pkg::reg_ctrl: cfg.sv_num <= wb_dat_w[13:8];
                    gps_pkg::reg_x1: begin
                        cfg.ini_x1a <= wb_dat_w[11:0];
                        cfg.ini_x1b <= wb_dat_w[23:12];
                    end
                    gps_pkg::reg_x2: begin
                        cfg.ini_x2a <= wb_dat_w[11:0];
                        cfg.ini_x2b <= wb_dat_w[23:12];
                    end
                    default: ;  // Status and capture are read only
                endcase
            end
        end
    end

    // Read mux
    always_comb begin
        rd_mux = '0;
        case (wb_adr)
            gps_pkg::reg_ctrl:   rd_mux[13:8] = cfg.sv_num;  // Start reads back 0
            gps_pkg::reg_status: rd_mux[1:0]  = {busy, done};
            gps_pkg::reg_x1:     rd_mux[23:0] = {cfg.ini_x1b, cfg.ini_x1a};
            gps_pkg::reg_x2:     rd_mux[23:0] = {cfg.ini_x2b, cfg.ini_x2a};
            gps_pkg::reg_ca:     rd_mux[12:0] = ca_word;
            default: begin
                if (wb_adr[3]) begin
                    rd_mux = p_pad[wb_adr[2:0]*32 +: 32];  // Word 0 holds newest chip
                end
            end
        endcase
    end

    // Read data registered with the ack
    always_ff @(posedge gps_clk_fast) begin
        if (acc) begin
            wb_dat_r <= rd_mux;
        end
    end

endmodule

// ==== logic/round_sequencer.sv ====
`timescale 1ns/100ps

module round_sequencer #(
    parameter int P_BITS = 64
) (
    input  logic                gps_clk_fast,
    input  logic                sync_rst_in,
    input  gps_pkg::round_cfg_t cfg,
    input  logic                start,
    output gps_pkg::gen_ctrl_t  ca_ctrl,
    output gps_pkg::gen_ctrl_t  p_ctrl,
    input  logic                ca_chip,
    input  logic                p_chip,
    output logic                busy,
    output logic                done,
    output gps_pkg::ca_word_t   ca_word,
    output logic [P_BITS-1:0]   p_word
);

    localparam int CW = $clog2(P_BITS);

    gps_pkg::seq_state_t state;
    logic [3:0]          ca_cnt;  // Enabled C/A steps
    logic [CW-1:0]       p_cnt;   // Enabled P steps
    logic                ca_cap;  // Chip valid, one cycle after enable
    logic                p_cap;
    logic                sv_ok;
    logic                accept;

    assign sv_ok  = (cfg.sv_num != 6'd0) && (cfg.sv_num <= 6'd32);
    assign accept = start && sv_ok &&
                    ((state == gps_pkg::seq_idle) || (state == gps_pkg::seq_done));
    assign busy   = (state == gps_pkg::seq_load) || (state == gps_pkg::seq_run);
    assign done   = (state == gps_pkg::seq_done);

    always_comb begin
        ca_ctrl.load   = (state == gps_pkg::seq_load);
        p_ctrl.load    = (state == gps_pkg::seq_load);
        // C/A stops early, 13 steps only
        ca_ctrl.enable = (state == gps_pkg::seq_run) && (ca_cnt != 4'(gps_pkg::ca_chips));
        p_ctrl.enable  = (state == gps_pkg::seq_run);
    end

    // ************************************************
    // Round FSM and capture
    // ************************************************
    always_ff @(posedge gps_clk_fast) begin
        if (sync_rst_in) begin
            state   <= gps_pkg::seq_idle;
            ca_cnt  <= '0;
            p_cnt   <= '0;
            ca_cap  <= 1'b0;
            p_cap   <= 1'b0;
            ca_word <= '0;
            p_word  <= '0;
        end else begin
            ca_cap <= ca_ctrl.enable;  // Generator latency
            p_cap  <= p_ctrl.enable;
            case (state)
                gps_pkg::seq_load: begin
                    state  <= gps_pkg::seq_run;
                    ca_cnt <= '0;
                    p_cnt  <= '0;
                end
                gps_pkg::seq_run: begin
                    p_cnt <= p_cnt + 1'b1;
                    if (ca_ctrl.enable) ca_cnt <= ca_cnt + 1'b1;
                    if (p_cnt == CW'(P_BITS - 1)) state <= gps_pkg::seq_done;
                end
                default: if (accept) state <= gps_pkg::seq_load;  // Idle or done
            endcase
            if (accept) begin
                ca_word <= '0;
                p_word  <= '0;
            end else begin
                if (ca_cap) ca_word <= {ca_word[11:0], ca_chip};
                if (p_cap)  p_word  <= {p_word[P_BITS-2:0], p_chip};
            end
        end
    end

endmodule

// ==== logic/ca_code_gen.sv ====
`timescale 1ns/100ps

module ca_code_gen (
    input  logic               gps_clk_fast,
    input  logic               sync_rst_in,
    input  gps_pkg::gen_ctrl_t ctrl,
    input  gps_pkg::sv_num_t   sv_num,
    output logic               chip
);

    logic [10:1] g1;      // Stage 10 is the output
    logic [10:1] g2;
    logic [3:0]  tap_a;   // G2 phase taps for this satellite
    logic [3:0]  tap_b;
    logic        g2_out;

    // ************************************************
    // Phase tap table, satellites 1 to 32
    // ************************************************
    always_comb begin
        case (sv_num)
            6'd1:  {tap_a, tap_b} = {4'd2, 4'd6};
            6'd2:  {tap_a, tap_b} = {4'd3, 4'd7};
            6'd3:  {tap_a, tap_b} = {4'd4, 4'd8};
            6'd4:  {tap_a, tap_b} = {4'd5, 4'd9};
            6'd5:  {tap_a, tap_b} = {4'd1, 4'd9};
            6'd6:  {tap_a, tap_b} = {4'd2, 4'd10};
            6'd7:  {tap_a, tap_b} = {4'd1, 4'd8};
            6'd8:  {tap_a, tap_b} = {4'd2, 4'd9};
            6'd9:  {tap_a, tap_b} = {4'd3, 4'd10};
            6'd10: {tap_a, tap_b} = {4'd2, 4'd3};
            6'd11: {tap_a, tap_b} = {4'd3, 4'd4};
            6'd12: {tap_a, tap_b} = {4'd5, 4'd6};
            6'd13: {tap_a, tap_b} = {4'd6, 4'd7};
            6'd14: {tap_a, tap_b} = {4'd7, 4'd8};
            6'd15: {tap_a, tap_b} = {4'd8, 4'd9};
            6'd16: {tap_a, tap_b} = {4'd9, 4'd10};
            6'd17: {tap_a, tap_b} = {4'd1, 4'd4};
            6'd18: {tap_a, tap_b} = {4'd2, 4'd5};
            6'd19: {tap_a, tap_b} = {4'd3, 4'd6};
            6'd20: {tap_a, tap_b} = {4'd4, 4'd7};
            6'd21: {tap_a, tap_b} = {4'd5, 4'd8};
            6'd22: {tap_a, tap_b} = {4'd6, 4'd9};
            6'd23: {tap_a, tap_b} = {4'd1, 4'd3};
            6'd24: {tap_a, tap_b} = {4'd4, 4'd6};
            6'd25: {tap_a, tap_b} = {4'd5, 4'd7};
            6'd26: {tap_a, tap_b} = {4'd6, 4'd8};
            6'd27: {tap_a, tap_b} = {4'd7, 4'd9};
            6'd28: {tap_a, tap_b} = {4'd8, 4'd10};
            6'd29: {tap_a, tap_b} = {4'd1, 4'd6};
            6'd30: {tap_a, tap_b} = {4'd2, 4'd7};
            6'd31: {tap_a, tap_b} = {4'd3, 4'd8};
            6'd32: {tap_a, tap_b} = {4'd4, 4'd9};
            default: {tap_a, tap_b} = {4'd1, 4'd1};  // Taps cancel, G1 only
        endcase
    end

    assign g2_out = g2[tap_a] ^ g2[tap_b];

    // G1 is 1+x3+x10, G2 is 1+x2+x3+x6+x8+x9+x10
    always_ff @(posedge gps_clk_fast) begin
        if (sync_rst_in) begin
            g1 <= '1;
            g2 <= '1;
        end else if (ctrl.load) begin
            g1 <= '1;  // All ones at round start
            g2 <= '1;
        end else if (ctrl.enable) begin
            g1 <= {g1[9:1], g1[3] ^ g1[10]};
            g2 <= {g2[9:1], g2[2] ^ g2[3] ^ g2[6] ^ g2[8] ^ g2[9] ^ g2[10]};
        end
    end

    // Chip from the state before the step
    always_ff @(posedge gps_clk_fast) begin
        if (ctrl.enable) chip <= g1[10] ^ g2_out;
    end

endmodule

// ==== logic/p_code_gen.sv ====
`timescale 1ns/100ps

module p_code_gen (
    input  logic                gps_clk_fast,
    input  logic                sync_rst_in,
    input  gps_pkg::gen_ctrl_t  ctrl,
    input  gps_pkg::round_cfg_t cfg,
    output logic                chip
);

    gps_pkg::lfsr12_t x1a;
    gps_pkg::lfsr12_t x1b;
    gps_pkg::lfsr12_t x2a;
    gps_pkg::lfsr12_t x2b;
    logic [36:0]      x2_dly;   // X2 history, newest in bit 0
    logic [37:0]      x2_hist;  // Current X2 plus history
    logic             x1_now;
    logic             x2_now;
    logic             x2_late;  // X2 delayed by sv_num chips

    // Same feedback taps for all four registers
    function automatic gps_pkg::lfsr12_t lfsr_step(input gps_pkg::lfsr12_t r);
        return {r[10:0], r[11] ^ r[10] ^ r[7] ^ r[5]};
    endfunction

    assign x1_now  = x1a[11] ^ x1b[11];
    assign x2_now  = x2a[11] ^ x2b[11];
    assign x2_hist = {x2_dly, x2_now};
    // Out of range delay reads zero
    assign x2_late = (cfg.sv_num <= 6'd37) ? x2_hist[cfg.sv_num] : 1'b0;

    // ************************************************
    // Registers and X2 delay line
    // ************************************************
    always_ff @(posedge gps_clk_fast) begin
        if (sync_rst_in) begin
            x1a    <= '0;
            x1b    <= '0;
            x2a    <= '0;
            x2b    <= '0;
            x2_dly <= '0;
        end else if (ctrl.load) begin
            x1a    <= cfg.ini_x1a;
            x1b    <= cfg.ini_x1b;
            x2a    <= cfg.ini_x2a;
            x2b    <= cfg.ini_x2b;
            x2_dly <= '0;  // Reads zero until filled
        end else if (ctrl.enable) begin
            x1a    <= lfsr_step(x1a);
            x1b    <= lfsr_step(x1b);
            x2a    <= lfsr_step(x2a);
            x2b    <= lfsr_step(x2b);
            x2_dly <= {x2_dly[35:0], x2_now};
        end
    end

    // Registered chip, one cycle latency
    always_ff @(posedge gps_clk_fast) begin
        if (ctrl.enable) begin
            chip <= x1_now ^ x2_late;
        end
    end

endmodule

// ==== logic/gps_code_top.sv ====
`timescale 1ns/100ps

module gps_code_top #(
    parameter int P_BITS = 64  // Multiple of 32, up to 256
) (
    input  logic              gps_clk_fast,
    input  logic              sync_rst_in,
    input  logic              wb_cyc,
    input  logic              wb_stb,
    input  logic              wb_we,
    input  gps_pkg::wb_addr_t wb_adr,
    input  gps_pkg::wb_data_t wb_dat_w,
    output gps_pkg::wb_data_t wb_dat_r,
    output logic              wb_ack
);

    gps_pkg::round_cfg_t cfg;
    gps_pkg::gen_ctrl_t  ca_ctrl;
    gps_pkg::gen_ctrl_t  p_ctrl;
    gps_pkg::ca_word_t   ca_word;
    logic [P_BITS-1:0]   p_word;
    logic                start;
    logic                busy;
    logic                done;
    logic                ca_chip;
    logic                p_chip;

    // ************************************************
    // Bus registers, sequencer, generators
    // ************************************************
    gps_wb_regs #(.P_BITS(P_BITS)) u_regs (
        .gps_clk_fast(gps_clk_fast), .sync_rst_in(sync_rst_in),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .cfg(cfg), .start(start), .busy(busy), .done(done),
        .ca_word(ca_word), .p_word(p_word)
    );

    round_sequencer #(.P_BITS(P_BITS)) u_seq (
        .gps_clk_fast(gps_clk_fast), .sync_rst_in(sync_rst_in),
        .cfg(cfg), .start(start), .ca_ctrl(ca_ctrl), .p_ctrl(p_ctrl),
        .ca_chip(ca_chip), .p_chip(p_chip), .busy(busy), .done(done),
        .ca_word(ca_word), .p_word(p_word)
    );

    ca_code_gen u_ca (
        .gps_clk_fast(gps_clk_fast), .sync_rst_in(sync_rst_in),
        .ctrl(ca_ctrl), .sv_num(cfg.sv_num), .chip(ca_chip)
    );

    p_code_gen u_p (
        .gps_clk_fast(gps_clk_fast), .sync_rst_in(sync_rst_in),
        .ctrl(p_ctrl), .cfg(cfg), .chip(p_chip)
    );

endmodule

// ==== sim/gps_clk_gen.sv ====
`timescale 1ns/100ps

module gps_clk_gen (
    output logic gps_clk_fast,
    output logic sync_rst_in
);

    initial begin
        gps_clk_fast = 1'b0;
        forever #50 gps_clk_fast = ~gps_clk_fast;  // 100 ns period
    end

    // Reset held for two rising edges, released on a falling edge
    initial begin
        sync_rst_in = 1'b1;
        repeat (2) @(posedge gps_clk_fast);
        @(negedge gps_clk_fast);
        sync_rst_in = 1'b0;
    end

endmodule

// ==== sim/gps_code_assert.sv ====
`timescale 1ns/100ps

module gps_code_assert (
    input logic                gps_clk_fast,
    input logic                sync_rst_in,
    input logic                wb_ack,
    input logic                start,
    input logic                busy,
    input logic                done,
    input gps_pkg::sv_num_t    sv_num,
    input gps_pkg::gen_ctrl_t  ca_ctrl,
    input gps_pkg::gen_ctrl_t  p_ctrl,
    input gps_pkg::seq_state_t state
);

    // ************************************************
    // Bus handshake
    // ************************************************
    ack_pulse: assert property (@(posedge gps_clk_fast) disable iff (sync_rst_in)
        wb_ack |=> !wb_ack)
        else $error("wb_ack held for more than one cycle");

    // ************************************************
    // Round sequencer
    // ************************************************
    // Accepted start gives one load cycle, then none
    load_once: assert property (@(posedge gps_clk_fast) disable iff (sync_rst_in)
        (start && !busy && sv_num != 6'd0 && sv_num <= 6'd32)
        |=> (ca_ctrl.load && p_ctrl.load) ##1 !(ca_ctrl.load || p_ctrl.load))
        else $error("load not a single cycle after start");

    idle_quiet: assert property (@(posedge gps_clk_fast) disable iff (sync_rst_in)
        (state == gps_pkg::seq_idle) |-> !(ca_ctrl.enable || p_ctrl.enable))
        else $error("generator enabled in idle state");

    done_busy: assert property (@(posedge gps_clk_fast) disable iff (sync_rst_in)
        !(done && busy))
        else $error("done and busy high together");

endmodule

// Attached at the top so the bus ack is visible too
bind gps_code_top gps_code_assert u_assert (
    .gps_clk_fast(gps_clk_fast),
    .sync_rst_in(sync_rst_in),
    .wb_ack(wb_ack),
    .start(start),
    .busy(busy),
    .done(done),
    .sv_num(cfg.sv_num),
    .ca_ctrl(ca_ctrl),
    .p_ctrl(p_ctrl),
    .state(u_seq.state)
);

// ==== sim/gps_tb.sv ====
`timescale 1ns/100ps

module gps_tb;

    localparam int P_BITS     = 64;
    localparam int ACK_LIMIT  = 16;   // Cycles to wait for ack
    localparam int POLL_LIMIT = 200;  // Status reads, two cycles each

    logic              gps_clk_fast;
    logic              sync_rst_in;
    logic              wb_cyc;
    logic              wb_stb;
    logic              wb_we;
    gps_pkg::wb_addr_t wb_adr;
    gps_pkg::wb_data_t wb_dat_w;
    gps_pkg::wb_data_t wb_dat_r;
    logic              wb_ack;

    int          errors;
    int          test_errs;
    int          checks;
    int          tests;
    logic [31:0] lfsr_state;   // Idle gap source

    gps_clk_gen u_clk (.gps_clk_fast(gps_clk_fast), .sync_rst_in(sync_rst_in));

    gps_code_top #(.P_BITS(P_BITS)) UUT (
        .gps_clk_fast(gps_clk_fast), .sync_rst_in(sync_rst_in),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
    );

    // Galois form, taps 32 30 26 25
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'ha300_0000) : (s >> 1);
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("Error: %s got %h expected %h", name, got, exp);
            errors++;
            test_errs++;
        end
    endtask

    task automatic idle_gap();
        logic [1:0] g;
        g = 2'd0;
        for (int i = 0; i < 2; i++) begin
            lfsr_state = lfsr_step(lfsr_state);  // One step per bit
            g = {g[0], lfsr_state[0]};
        end
        repeat (g) @(negedge gps_clk_fast);
    endtask

    // ************************************************
    // Wishbone classic master
    // ************************************************
    task automatic bus_access(input logic we, input gps_pkg::wb_addr_t adr,
                              input gps_pkg::wb_data_t wdata,
                              output gps_pkg::wb_data_t rdata);
        logic got;
        int   n;
        got = 1'b0;
        n = 0;
        @(negedge gps_clk_fast);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdata;
        while (!got && n < ACK_LIMIT) begin
            @(negedge gps_clk_fast);  // Ack and data settled here
            got = wb_ack;
            n++;
        end
        rdata  = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        if (!got) begin
            $display("Bus timeout, no acknowledge for address %0d", adr);
            errors++;
            test_errs++;
        end
        idle_gap();
    endtask

    task automatic bus_write(input gps_pkg::wb_addr_t adr, input gps_pkg::wb_data_t d);
        gps_pkg::wb_data_t unused;
        bus_access(1'b1, adr, d, unused);
    endtask

    task automatic bus_read(input gps_pkg::wb_addr_t adr, output gps_pkg::wb_data_t d);
        bus_access(1'b0, adr, '0, d);
    endtask

    task automatic wait_done();
        gps_pkg::wb_data_t st;
        int                n;
        st = '0;
        n = 0;
        while (!st[0] && n < POLL_LIMIT) begin
            bus_read(gps_pkg::reg_status, st);
            n++;
        end
        if (!st[0]) begin
            $display("Round never reached done within 400 cycles");
            errors++;
            test_errs++;
        end
        check_value("status", st, 32'h1);  // Done, not busy
    endtask

    task automatic end_test(input string name);
        tests++;
        if (test_errs == 0) $display("Test %0d %s: ok", tests, name);
        else $display("Test %0d %s: %0d errors", tests, name, test_errs);
        test_errs = 0;
    endtask

    // Mode 0 full round, 1 sv_num only, 2 start written twice with X1 changed between
    task automatic run_round(input logic [31:0] mode, input gps_pkg::sv_num_t sv,
                             input logic [31:0] x1, input logic [31:0] x2,
                             input logic [31:0] ca, input logic [31:0] p1,
                             input logic [31:0] p0);
        gps_pkg::wb_data_t rd;
        gps_pkg::wb_data_t ctrl;
        gps_pkg::wb_data_t x1_last;  // Last value written to reg_x1
        ctrl    = {18'd0, sv, 7'd0, 1'b1};
        x1_last = x1;
        if (mode != 32'd1) begin
            bus_write(gps_pkg::reg_x1, x1);
            bus_write(gps_pkg::reg_x2, x2);
        end
        bus_write(gps_pkg::reg_ctrl, ctrl);
        if (mode == 32'd2) begin
            // New X1A seed, only a wrongly accepted restart would load it
            x1_last = x1 ^ 32'h0000_0800;
            bus_write(gps_pkg::reg_x1, x1_last);
            bus_write(gps_pkg::reg_ctrl, ctrl);  // Lands while busy
        end
        wait_done();
        bus_read(gps_pkg::reg_ca, rd);
        check_value("ca_word", rd, ca);
        bus_read(gps_pkg::reg_p0, rd);
        check_value("p_word0", rd, p0);
        bus_read(gps_pkg::reg_p0 + 4'd1, rd);
        check_value("p_word1", rd, p1);
        // Configuration readback
        bus_read(gps_pkg::reg_x1, rd);
        check_value("reg_x1", rd, x1_last);
        bus_read(gps_pkg::reg_x2, rd);
        check_value("reg_x2", rd, x2);
        bus_read(gps_pkg::reg_ctrl, rd);
        check_value("reg_ctrl", rd, {18'd0, sv, 8'd0});
    endtask

    // ************************************************
    // Main sequence
    // ************************************************
    initial begin
        int                fd;
        int                n;
        string             line;
        logic [31:0]       f_mode;
        logic [31:0]       f_sv;
        logic [31:0]       f_x1;
        logic [31:0]       f_x2;
        logic [31:0]       f_ca;
        logic [31:0]       f_p1;
        logic [31:0]       f_p0;
        gps_pkg::wb_data_t rd;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_we      = 1'b0;
        wb_adr     = '0;
        wb_dat_w   = '0;
        errors     = 0;
        test_errs  = 0;
        checks     = 0;
        tests      = 0;
        lfsr_state = 32'h0c86_ec83;
        n = 0;
        while (sync_rst_in !== 1'b0 && n < 10) begin
            @(negedge gps_clk_fast);
            n++;
        end
        if (sync_rst_in !== 1'b0) begin
            $display("Reset was never released");
            errors++;
        end

        bus_read(gps_pkg::reg_status, rd);
        check_value("status", rd, 32'h0);
        bus_read(gps_pkg::reg_ca, rd);
        check_value("ca_word", rd, 32'h0);
        bus_read(gps_pkg::reg_p0, rd);
        check_value("p_word0", rd, 32'h0);
        end_test("reset values");

        fd = $fopen("sim/gps_patterns.txt", "r");
        if (fd == 0) begin
            $display("Pattern file sim/gps_patterns.txt could not be opened");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n > 0 && line.len() > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h",
                                f_mode, f_sv, f_x1, f_x2, f_ca, f_p1, f_p0);
                    if (n == 7) begin
                        run_round(f_mode, f_sv[5:0], f_x1, f_x2, f_ca, f_p1, f_p0);
                        end_test($sformatf("round mode %0d sv %0d", f_mode, f_sv));
                    end
                end
            end
            $fclose(fd);
        end

        $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0 && tests > 1) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Overall limit on simulated time
    initial begin
        #2_000_000;
        $display("Simulation time limit reached before the end of the tests");
        $display("Simulation failed");
        $finish;
    end

endmodule

// ==== sim/gps_patterns.txt ====
# mode sv_num reg_x1 reg_x2 ca_word p_word1 p_word0 (hex)
# mode 0 full round, 1 sv_num change only, 2 start written twice while busy
0 01 00A53000 00000000 1907 A53F37FD 8BCD3CBA
0 05 00000000 00000A53 12D8 0529F9BF EC5E69E5
1 02 00000000 00000A53 1C87 294FCDFF 62F34F2E
2 01 00000A53 00000000 1907 A53F37FD 8BCD3CBA
0 03 00000A53 00A53000 1E47 B198D102 3AB49B2D

// ==== gps_code_top.f ====
logic/gps_pkg.sv
logic/gps_wb_regs.sv
logic/round_sequencer.sv
logic/ca_code_gen.sv
logic/p_code_gen.sv
logic/gps_code_top.sv
sim/gps_clk_gen.sv
sim/gps_code_assert.sv
sim/gps_tb.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module gps_tb -f gps_code_top.f -o gps_sim
	./obj_dir/gps_sim | tee $(LOG)
	grep -q "^Simulation completed successfully$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
